/* test/backend_patterns.txt */
# kind v src rd we alu mem csr_old csr_idx cwen csr_new exit stall flush rs1 rs2 csr_rd exp
# all hex; kind R checks rs1_val after commit, C checks csr_rd_val, N has only model checks
R 1 0 01 1 00001111 aaaa0000 bbbb0000 000 0 00000000 0 0 0 01 02 340 00001111
R 1 1 02 1 11110000 00002222 bbbb0000 000 0 00000000 0 0 0 02 01 340 00002222
R 1 2 03 1 11110000 aaaa0000 00003333 000 0 00000000 0 0 0 03 02 340 00003333
R 1 0 00 1 12345678 aaaa0000 bbbb0000 000 0 00000000 0 0 0 00 01 340 00000000
R 1 0 04 1 44444444 aaaa0000 bbbb0000 000 0 00000000 0 0 0 04 04 340 44444444
R 1 0 04 0 55555555 aaaa0000 bbbb0000 000 0 00000000 0 0 0 04 03 340 44444444
R 1 0 05 1 05050505 aaaa0000 bbbb0000 000 0 00000000 0 1 0 05 04 340 05050505
R 1 0 06 1 06060606 aaaa0000 bbbb0000 000 0 00000000 0 0 1 06 05 340 00000000
R 1 0 07 1 07070707 aaaa0000 bbbb0000 000 0 00000000 0 1 1 07 06 340 07070707
R 1 1 01 1 99999999 0101abcd bbbb0000 000 0 00000000 0 0 0 01 02 340 0101abcd
R 0 0 08 1 08080808 aaaa0000 bbbb0000 000 0 00000000 0 0 0 08 01 340 00000000
R 1 0 02 1 22220000 aaaa0000 bbbb0000 000 0 00000000 0 0 1 02 01 340 00002222
C 1 0 00 0 00000000 00000000 00000000 340 1 cafe0001 0 0 0 00 00 340 cafe0001
C 1 0 00 0 00000000 00000000 00000000 305 1 80000103 0 0 0 00 00 305 80000100
C 1 0 00 0 00000000 00000000 00000000 341 1 00001235 0 0 0 00 00 341 00001234
C 1 0 00 0 00000000 00000000 00000000 342 1 8000000b 0 0 0 00 00 342 8000000b
C 1 0 00 0 00000000 00000000 00000000 300 1 ffffffff 0 0 0 00 00 300 00000000
C 0 0 00 0 00000000 00000000 00000000 340 1 ffffffff 0 0 0 00 00 340 cafe0001
C 0 0 00 0 00000000 00000000 00000000 305 1 ffffffff 0 0 0 00 00 305 80000100
C 0 0 00 0 00000000 00000000 00000000 341 1 ffffffff 0 0 0 00 00 341 00001234
C 0 0 00 0 00000000 00000000 00000000 342 1 ffffffff 0 0 0 00 00 342 8000000b
C 1 0 00 0 00000000 00000000 00000000 340 1 0badf00d 0 1 0 00 00 340 0badf00d
C 1 0 00 0 00000000 00000000 00000000 340 1 11111111 0 0 1 00 00 340 0badf00d
R 1 2 09 1 00000000 00000000 0badf00d 340 1 12121212 0 0 0 09 00 340 0badf00d
C 1 0 00 0 00000000 00000000 00000000 305 1 00000003 0 0 0 00 00 305 00000000
R 1 0 0a 1 0a0a0a0a aaaa0000 bbbb0000 000 0 00000000 1 0 0 0a 09 340 0a0a0a0a
R 0 0 0b 1 0b0b0b0b aaaa0000 bbbb0000 000 0 00000000 1 0 0 0b 0a 340 00000000
N 1 0 00 0 00000000 00000000 00000000 000 0 00000000 1 1 0 0a 00 340 00000000
R 1 1 1f 1 00000000 1f1f1f1f bbbb0000 000 0 00000000 0 0 0 1f 1e 340 1f1f1f1f
R 1 0 1e 1 fedcba98 aaaa0000 bbbb0000 000 0 00000000 0 0 0 1f 1e 340 1f1f1f1f
C 1 2 0c 1 00000000 00000000 80000000 342 1 00000007 0 0 0 0c 00 342 00000007

/* letc_core_backend.f */
rtl/letc_pkg.sv
rtl/letc_core_pkg.sv
rtl/letc_core_stage_writeback.sv
rtl/letc_core_rf.sv
rtl/letc_core_csrf.sv
rtl/letc_core_forwarder.sv
rtl/letc_core_backend.sv
test/letc_core_backend_tb.sv

/* Makefile */
# Verilator flow for the writeback backend

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module letc_core_backend \
		rtl/letc_pkg.sv rtl/letc_core_pkg.sv rtl/letc_core_stage_writeback.sv \
		rtl/letc_core_rf.sv rtl/letc_core_csrf.sv rtl/letc_core_forwarder.sv \
		rtl/letc_core_backend.sv

sim:
	verilator --binary --timing --top-module letc_core_backend_tb \
		-f letc_core_backend.f --Mdir obj_dir
	./obj_dir/Vletc_core_backend_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* test/letc_core_backend_tb.sv */
`default_nettype none

module letc_core_backend_tb;

    // one operation read from the pattern file
    typedef struct packed {
        logic [7:0]              kind;
        logic                    valid;
        letc_core_pkg::m2_to_w_s pkt;
        logic                    stall;
        logic                    flush;
        letc_pkg::reg_idx_t      rs1;
        letc_pkg::reg_idx_t      rs2;
        letc_pkg::csr_idx_t      csr_rd;
        letc_pkg::word_t         exp;
    } pattern_t;

    logic                    clk;
    logic                    rst_n;
    logic                    m2_to_w_valid;
    letc_core_pkg::m2_to_w_s m2_to_w;
    logic                    stall;
    logic                    flush;
    letc_pkg::reg_idx_t      rs1_idx;
    letc_pkg::reg_idx_t      rs2_idx;
    letc_pkg::csr_idx_t      csr_rd_idx;
    letc_pkg::word_t         rs1_val;
    letc_pkg::word_t         rs2_val;
    letc_pkg::word_t         csr_rd_val;
    logic                    exit_req;

    // reference state of the rf and csrs
    // csr slots in order mscratch mtvec mepc mcause
    letc_pkg::word_t model_rf [32];
    letc_pkg::word_t model_csr [4];

    pattern_t patterns [$];
    int       error_count;
    int       pass_count;
    int       fail_count;
    int       cycles = 0;
    int       cycle_limit;
    int       seed;

    letc_core_backend UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .m2_to_w_valid (m2_to_w_valid),
        .m2_to_w       (m2_to_w),
        .stall         (stall),
        .flush         (flush),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .csr_rd_idx    (csr_rd_idx),
        .csr_rd_val    (csr_rd_val),
        .exit_req      (exit_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // destination value by the select rules
    function automatic letc_pkg::word_t select_rd_value(letc_core_pkg::m2_to_w_s pkt);
        case (pkt.rd_src)
            letc_core_pkg::RD_SRC_ALU: return pkt.alu_result;
            letc_core_pkg::RD_SRC_MEM: return pkt.mem_rdata;
            letc_core_pkg::RD_SRC_CSR: return pkt.csr_old_val;
            default:                   return letc_core_pkg::POISON_WORD;
        endcase
    endfunction

    // operand seen in the held cycle before the rf write lands
    function automatic letc_pkg::word_t held_operand(pattern_t p, letc_pkg::reg_idx_t src);
        if (p.valid && p.pkt.rd_we && (p.pkt.rd_idx != 5'd0) && (p.pkt.rd_idx == src)) begin
            return select_rd_value(p.pkt);
        end
        return model_rf[src];
    endfunction

    function automatic letc_pkg::word_t read_model_csr(letc_pkg::csr_idx_t idx);
        case (idx)
            letc_pkg::CSR_MSCRATCH: return model_csr[0];
            letc_pkg::CSR_MTVEC:    return model_csr[1];
            letc_pkg::CSR_MEPC:     return model_csr[2];
            letc_pkg::CSR_MCAUSE:   return model_csr[3];
            default:                return '0;
        endcase
    endfunction

    // mtvec keeps direct mode and mepc stays even
    task automatic write_model_csr(letc_pkg::csr_idx_t idx, letc_pkg::word_t data);
        case (idx)
            letc_pkg::CSR_MSCRATCH: model_csr[0] = data;
            letc_pkg::CSR_MTVEC:    model_csr[1] = {data[31:2], 2'b00};
            letc_pkg::CSR_MEPC:     model_csr[2] = {data[31:1], 1'b0};
            letc_pkg::CSR_MCAUSE:   model_csr[3] = data;
            default: ;
        endcase
    endtask

    task automatic write_model_reg(letc_pkg::reg_idx_t idx, letc_pkg::word_t val);
        if (idx != 5'd0) begin
            model_rf[idx] = val;
        end
    endtask

    task automatic compare_word(string name, letc_pkg::word_t got, letc_pkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // sample mid cycle well clear of both edges
    task automatic check_held(pattern_t p);
        #5;
        compare_word("rs1_val", rs1_val, held_operand(p, p.rs1));
        compare_word("rs2_val", rs2_val, held_operand(p, p.rs2));
        compare_word("csr_rd_val", csr_rd_val, read_model_csr(p.csr_rd));
        compare_flag("exit_req", exit_req, p.valid && p.pkt.sim_exit_req);
    endtask

    task automatic report_test(string name, int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s ok", name);
        end else begin
            fail_count++;
            $display("%s failed", name);
        end
    endtask

    // lines starting with # are column notes
    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] col [17];
        pattern_t    p;
        fd = $fopen("test/backend_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line.substr(2, line.len() - 1),
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16]);
            if (n != 17) begin
                $display("pattern line could not be parsed: %s", line);
                error_count++;
                continue;
            end
            p = '0;
            p.kind                 = line.getc(0);
            p.valid                = col[0][0];
            p.pkt.rd_src           = letc_core_pkg::rd_src_e'(col[1][1:0]);
            p.pkt.rd_idx           = col[2][4:0];
            p.pkt.rd_we            = col[3][0];
            p.pkt.alu_result       = col[4];
            p.pkt.mem_rdata        = col[5];
            p.pkt.csr_old_val      = col[6];
            p.pkt.csr_idx          = col[7][11:0];
            p.pkt.csr_expl_wen     = col[8][0];
            p.pkt.csr_new_val      = col[9];
            p.pkt.sim_exit_req     = col[10][0];
            p.stall                = col[11][0];
            p.flush                = col[12][0];
            p.rs1                  = col[13][4:0];
            p.rs2                  = col[14][4:0];
            p.csr_rd               = col[15][11:0];
            p.exp                  = col[16];
            patterns.push_back(p);
        end
        $fclose(fd);
    endtask

    task automatic run_pattern(pattern_t p, int num);
        int              errors_before;
        letc_pkg::word_t model_val;
        errors_before = error_count;
        // packet offered for the next rising edge
        @(negedge clk);
        m2_to_w_valid = p.valid;
        m2_to_w       = p.pkt;
        stall         = 1'b0;
        flush         = 1'b0;
        rs1_idx       = p.rs1;
        rs2_idx       = p.rs2;
        csr_rd_idx    = p.csr_rd;
        // held cycle with a bubble behind it
        @(negedge clk);
        m2_to_w_valid = 1'b0;
        stall         = p.stall;
        flush         = p.flush;
        check_held(p);
        if (p.stall) begin
            repeat (2) begin
                @(negedge clk);
                check_held(p);
            end
            // stall and flush drop together
            @(negedge clk);
            stall = 1'b0;
            flush = 1'b0;
            check_held(p);
        end
        // flush only kills an unstalled held cycle
        if (p.valid && (p.stall || !p.flush)) begin
            if (p.pkt.rd_we) begin
                write_model_reg(p.pkt.rd_idx, select_rd_value(p.pkt));
            end
            if (p.pkt.csr_expl_wen) begin
                write_model_csr(p.pkt.csr_idx, p.pkt.csr_new_val);
            end
        end
        @(negedge clk);
        flush = 1'b0;
        #5;
        compare_word("rs1_val", rs1_val, model_rf[p.rs1]);
        compare_word("rs2_val", rs2_val, model_rf[p.rs2]);
        compare_word("csr_rd_val", csr_rd_val, read_model_csr(p.csr_rd));
        compare_flag("exit_req", exit_req, 1'b0);
        // file value for kinds that carry one
        if (p.kind == "R" || p.kind == "C") begin
            model_val = (p.kind == "R") ? model_rf[p.rs1] : read_model_csr(p.csr_rd);
            if (model_val !== p.exp) begin
                $display("pattern %0d expects %h but the model gives %h", num, p.exp, model_val);
                error_count++;
            end
            if (p.kind == "R") begin
                compare_word("rs1_val", rs1_val, p.exp);
            end else begin
                compare_word("csr_rd_val", csr_rd_val, p.exp);
            end
        end
        report_test($sformatf("pattern %0d kind %c", num, p.kind), errors_before);
    endtask

    // back to back alu writes followed by a full register sweep
    task automatic run_stress();
        int                      errors_before;
        int                      rnd;
        letc_core_pkg::m2_to_w_s pkt;
        errors_before = error_count;
        repeat (40) begin
            @(negedge clk);
            pkt            = '0;
            pkt.rd_src     = letc_core_pkg::RD_SRC_ALU;
            pkt.rd_we      = 1'b1;
            rnd            = $random(seed);
            pkt.rd_idx     = rnd[4:0];
            pkt.alu_result = $random(seed);
            pkt.mem_rdata  = $random(seed);
            m2_to_w_valid  = 1'b1;
            m2_to_w        = pkt;
            write_model_reg(pkt.rd_idx, pkt.alu_result);
        end
        @(negedge clk);
        m2_to_w_valid = 1'b0;
        // first read two cycles after the last write
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rs1_idx = r[4:0];
            rs2_idx = 5'd31 - r[4:0];
            #5;
            compare_word("rs1_val", rs1_val, model_rf[rs1_idx]);
            compare_word("rs2_val", rs2_val, model_rf[rs2_idx]);
        end
        report_test("random alu writes", errors_before);
    endtask

    initial begin
        rst_n         = 1'b0;
        // exit packet offered during reset must not survive it
        m2_to_w_valid = 1'b1;
        m2_to_w       = '0;
        m2_to_w.sim_exit_req = 1'b1;
        stall         = 1'b0;
        flush         = 1'b0;
        rs1_idx       = '0;
        rs2_idx       = '0;
        csr_rd_idx    = letc_pkg::CSR_MTVEC;
        error_count   = 0;
        pass_count    = 0;
        fail_count    = 0;
        cycle_limit   = 400;
        seed          = 32'hd51b_dfd9;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            model_csr[i] = '0;
        end
        load_patterns();
        // 8 cycles per line plus 400 for the sweep
        cycle_limit = patterns.size() * 8 + 400;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n         = 1'b1;
        m2_to_w_valid = 1'b0;
        m2_to_w       = '0;
        #5;
        compare_flag("exit_req", exit_req, 1'b0);
        compare_word("csr_rd_val", csr_rd_val, 32'h0);
        report_test("reset state", 0);
        for (int i = 0; i < patterns.size(); i++) begin
            run_pattern(patterns[i], i + 1);
        end
        run_stress();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : letc_core_backend_tb

`default_nettype wire

/* rtl/letc_core_backend.sv */
`default_nettype none

module letc_core_backend (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    // packet from the second memory stage
    input  wire logic                    m2_to_w_valid,
    input  wire letc_core_pkg::m2_to_w_s m2_to_w,

    // pipeline control
    input  wire logic                    stall,
    input  wire logic                    flush,

    // decode operand lookup
    input  wire letc_pkg::reg_idx_t      rs1_idx,
    input  wire letc_pkg::reg_idx_t      rs2_idx,
    output letc_pkg::word_t              rs1_val,
    output letc_pkg::word_t              rs2_val,

    // csr read for the memory stages
    input  wire letc_pkg::csr_idx_t      csr_rd_idx,
    output letc_pkg::word_t              csr_rd_val,

    // simulation end request
    output logic                         exit_req
);

    // writeback commit and bypass records
    letc_core_pkg::rf_wr_s  rf_wr;
    letc_core_pkg::csr_wr_s csr_wr;
    letc_core_pkg::fwd_s    w_fwd;

    // register file data before bypass
    letc_pkg::word_t rf_rs1_val;
    letc_pkg::word_t rf_rs2_val;

    letc_core_stage_writeback stage_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .flush         (flush),
        .m2_to_w_valid (m2_to_w_valid),
        .m2_to_w       (m2_to_w),
        .rf_wr         (rf_wr),
        .csr_wr        (csr_wr),
        .fwd           (w_fwd),
        .exit_req      (exit_req)
    );

    // decode indices go straight to the read ports
    letc_core_rf rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (rf_wr),
        .ra_idx (rs1_idx),
        .ra_val (rf_rs1_val),
        .rb_idx (rs2_idx),
        .rb_val (rf_rs2_val)
    );

    letc_core_csrf csrf (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (csr_wr),
        .rd_idx (csr_rd_idx),
        .rd_val (csr_rd_val)
    );

    // covers the cycle before the rf write lands
    letc_core_forwarder forwarder (
        .w_fwd      (w_fwd),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rf_rs1_val (rf_rs1_val),
        .rf_rs2_val (rf_rs2_val),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val)
    );

endmodule : letc_core_backend

`default_nettype wire

/* rtl/letc_core_forwarder.sv */
`default_nettype none

module letc_core_forwarder (
    // bypass record from writeback
    input  wire letc_core_pkg::fwd_s w_fwd,

    // decode source indices
    input  wire letc_pkg::reg_idx_t  rs1_idx,
    input  wire letc_pkg::reg_idx_t  rs2_idx,

    // raw register file read data
    input  wire letc_pkg::word_t     rf_rs1_val,
    input  wire letc_pkg::word_t     rf_rs2_val,

    // resolved operands
    output letc_pkg::word_t          rs1_val,
    output letc_pkg::word_t          rs2_val
);

    // hit flags, mostly useful in waves
    logic rs1_hit;
    logic rs2_hit;

    // raw hazard on one source
    // x0 never matches, its value is always zero
    function automatic logic src_hit(
        input letc_core_pkg::fwd_s rec,
        input letc_pkg::reg_idx_t  src_idx
    );
        logic idx_match;
        idx_match = (rec.rd_idx == src_idx);
        return rec.produces_rd && idx_match && (src_idx != 5'd0);
    endfunction

    assign rs1_hit = src_hit(w_fwd, rs1_idx);
    assign rs2_hit = src_hit(w_fwd, rs2_idx);

    // operand 1
    // writeback value wins over the stale rf copy
    always_comb begin
        if (rs1_hit) begin
            rs1_val = w_fwd.rd_val;
        end else begin
            rs1_val = rf_rs1_val;
        end
    end

    // operand 2
    always_comb begin
        if (rs2_hit) begin
            rs2_val = w_fwd.rd_val;
        end else begin
            rs2_val = rf_rs2_val;
        end
    end

endmodule : letc_core_forwarder

`default_nettype wire

/* rtl/letc_core_csrf.sv */
`default_nettype none

module letc_core_csrf (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // explicit write from writeback
    input  wire letc_core_pkg::csr_wr_s wr,

    // combinational read port
    input  wire letc_pkg::csr_idx_t     rd_idx,
    output letc_pkg::word_t             rd_val
);

    // machine csr storage
    letc_pkg::word_t mscratch;
    letc_pkg::word_t mtvec;
    letc_pkg::word_t mepc;
    letc_pkg::word_t mcause;

    // write enables decoded from the address
    logic mscratch_we;
    logic mtvec_we;
    logic mepc_we;
    logic mcause_we;

    // unimplemented addresses decode to nothing
    assign mscratch_we = wr.we && (wr.idx == letc_pkg::CSR_MSCRATCH);
    assign mtvec_we    = wr.we && (wr.idx == letc_pkg::CSR_MTVEC);
    assign mepc_we     = wr.we && (wr.idx == letc_pkg::CSR_MEPC);
    assign mcause_we   = wr.we && (wr.idx == letc_pkg::CSR_MCAUSE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else begin
            // any value allowed
            if (mscratch_we) begin
                mscratch <= wr.wdata;
            end
            // mode field forced to direct
            if (mtvec_we) begin
                mtvec <= {wr.wdata[31:2], 2'b00};
            end
            // halfword aligned pc, bit 0 always clear
            if (mepc_we) begin
                mepc <= {wr.wdata[31:1], 1'b0};
            end
            if (mcause_we) begin
                mcause <= wr.wdata;
            end
        end
    end

    // read mux, zero for anything not implemented
    always_comb begin
        case (rd_idx)
            letc_pkg::CSR_MSCRATCH: rd_val = mscratch;
            letc_pkg::CSR_MTVEC:    rd_val = mtvec;
            letc_pkg::CSR_MEPC:     rd_val = mepc;
            letc_pkg::CSR_MCAUSE:   rd_val = mcause;
            default:                rd_val = '0;
        endcase
    end

endmodule : letc_core_csrf

`default_nettype wire

/* rtl/letc_core_rf.sv */
`default_nettype none

module letc_core_rf (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // write port from writeback
    input  wire letc_core_pkg::rf_wr_s wr,

    // read port a
    input  wire letc_pkg::reg_idx_t    ra_idx,
    output letc_pkg::word_t            ra_val,

    // read port b
    input  wire letc_pkg::reg_idx_t    rb_idx,
    output letc_pkg::word_t            rb_val
);

    // x1 to x31, x0 has no storage
    letc_pkg::word_t regs [31:1];

    // synchronous write, x0 writes dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && (wr.idx != 5'd0)) begin
            regs[wr.idx] <= wr.val;
        end
    end

    // combinational read a
    // x0 is hardwired to zero
    always_comb begin
        if (ra_idx == 5'd0) begin
            ra_val = '0;
        end else begin
            ra_val = regs[ra_idx];
        end
    end

    // combinational read b
    // same x0 rule as port a
    always_comb begin
        if (rb_idx == 5'd0) begin
            rb_val = '0;
        end else begin
            rb_val = regs[rb_idx];
        end
    end

endmodule : letc_core_rf

`default_nettype wire

/* rtl/letc_core_stage_writeback.sv */
`default_nettype none

module letc_core_stage_writeback (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // pipeline control
    input  wire logic                   stall,
    input  wire logic                   flush,

    // packet from the second memory stage
    input  wire logic                   m2_to_w_valid,
    input  wire letc_core_pkg::m2_to_w_s m2_to_w,

    // commit ports
    output letc_core_pkg::rf_wr_s       rf_wr,
    output letc_core_pkg::csr_wr_s      csr_wr,

    // bypass record for decode operands
    output letc_core_pkg::fwd_s         fwd,

    // simulation end request
    output logic                        exit_req
);

    // control part of the pipeline register
    logic ff_in_valid;

    // payload part of the pipeline register
    letc_core_pkg::m2_to_w_s ff_in;

    // held packet may commit this cycle
    logic commit_ok;

    // selected destination value
    letc_pkg::word_t rd_val;

    // valid bit follows the input unless stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_in_valid <= 1'b0;
        end else if (!stall) begin
            ff_in_valid <= m2_to_w_valid;
        end
    end

    // payload captured on the same edges as valid
    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_in <= m2_to_w;
        end
    end

    // flush only masks this cycle, the register keeps the packet
    assign commit_ok = ff_in_valid && !stall && !flush;

    // destination value mux
    always_comb begin
        case (ff_in.rd_src)
            letc_core_pkg::RD_SRC_ALU: rd_val = ff_in.alu_result;
            letc_core_pkg::RD_SRC_MEM: rd_val = ff_in.mem_rdata;
            letc_core_pkg::RD_SRC_CSR: rd_val = ff_in.csr_old_val;
            // undefined select, poison makes it obvious in waves
            default:                   rd_val = letc_core_pkg::POISON_WORD;
        endcase
    end

    // register file commit
    assign rf_wr.we  = commit_ok && ff_in.rd_we;
    assign rf_wr.idx = ff_in.rd_idx;
    assign rf_wr.val = rd_val;

    // csr commit, bubbles never write
    assign csr_wr.we    = commit_ok && ff_in.csr_expl_wen;
    assign csr_wr.idx   = ff_in.csr_idx;
    assign csr_wr.wdata = ff_in.csr_new_val;

    // bypass ignores stall and flush
    assign fwd.produces_rd = ff_in_valid && ff_in.rd_we;
    assign fwd.rd_idx      = ff_in.rd_idx;
    assign fwd.rd_val      = rd_val;

    // exit seen whenever the held packet asks for it
    assign exit_req = ff_in_valid && ff_in.sim_exit_req;

endmodule : letc_core_stage_writeback

`default_nettype wire

/* rtl/letc_core_pkg.sv */
`default_nettype none

package letc_core_pkg;

    // value driven when the destination select is not a defined source
    localparam letc_pkg::word_t POISON_WORD = 32'hdead_beef;

    // where the destination register value comes from
    typedef enum logic [1:0] {
        // integer result from execute
        RD_SRC_ALU = 2'd0,
        // load data from the memory stages
        RD_SRC_MEM = 2'd1,
        // csr value before the explicit write
        RD_SRC_CSR = 2'd2
    } rd_src_e;

    // packet from the second memory stage into writeback
    typedef struct packed {
        // destination value select
        rd_src_e            rd_src;
        letc_pkg::reg_idx_t rd_idx;
        logic               rd_we;
        // candidate destination values
        letc_pkg::word_t    alu_result;
        letc_pkg::word_t    mem_rdata;
        letc_pkg::word_t    csr_old_val;
        // explicit csr write from a csr instruction
        letc_pkg::csr_idx_t csr_idx;
        logic               csr_expl_wen;
        letc_pkg::word_t    csr_new_val;
        // simulation end request, e.g. from an ecall used as a marker
        logic               sim_exit_req;
    } m2_to_w_s;

    // what writeback offers for operand bypass
    typedef struct packed {
        logic               produces_rd;
        letc_pkg::reg_idx_t rd_idx;
        letc_pkg::word_t    rd_val;
    } fwd_s;

    // register file write port
    typedef struct packed {
        logic               we;
        letc_pkg::reg_idx_t idx;
        letc_pkg::word_t    val;
    } rf_wr_s;

    // csr file explicit write port
    typedef struct packed {
        logic               we;
        letc_pkg::csr_idx_t idx;
        letc_pkg::word_t    wdata;
    } csr_wr_s;

endpackage : letc_core_pkg

`default_nettype wire

/* rtl/letc_pkg.sv */
`default_nettype none

package letc_pkg;

    // width of an integer register and of a data word
    localparam int XLEN = 32;

    // one architectural data word
    typedef logic [XLEN-1:0] word_t;

    // integer register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // csr address space, 4096 entries
    typedef logic [11:0] csr_idx_t;

    // machine mode csrs implemented by the backend
    // scratch word for the trap handler
    localparam csr_idx_t CSR_MSCRATCH = 12'h340;

    // trap vector base, direct mode only
    localparam csr_idx_t CSR_MTVEC = 12'h305;

    // pc of the instruction that trapped
    localparam csr_idx_t CSR_MEPC = 12'h341;

    // trap cause code
    localparam csr_idx_t CSR_MCAUSE = 12'h342;

endpackage : letc_pkg

`default_nettype wire
